/* design/axi_mux_pkg.sv */
// ----------------------------------------------------------
// AXI write mux shared definitions
// Bus widths and packed channel payloads for upstream
// and downstream sides of the write path
// ----------------------------------------------------------

package axi_mux_pkg;

  // ----------------------------------------------------------
  // Widths
  // ----------------------------------------------------------
  localparam int unsigned ADDR_W   = 32;                // Address width
  localparam int unsigned DATA_W   = 32;                // Data width
  localparam int unsigned STRB_W   = DATA_W / 8;        // One strobe per byte
  localparam int unsigned SLV_ID_W = 4;                 // Upstream ID width
  localparam int unsigned IDX_W    = 2;                 // Port prefix, up to 4 ports
  localparam int unsigned MST_ID_W = SLV_ID_W + IDX_W;  // Downstream ID width

  typedef logic [IDX_W-1:0] port_idx_t;                 // Upstream port number

  // ----------------------------------------------------------
  // Channel payloads
  // ----------------------------------------------------------
  // Upstream AW, 49 bits
  typedef struct packed {
    logic [SLV_ID_W-1:0] id;
    logic [ADDR_W-1:0]   addr;
    logic [7:0]          len;    // Beats minus one
    logic [2:0]          size;   // Bytes per beat, log2
    logic [1:0]          burst;  // FIXED / INCR / WRAP
  } slv_aw_t;

  // Downstream AW, ID carries the port prefix on top
  typedef struct packed {
    logic [MST_ID_W-1:0] id;
    logic [ADDR_W-1:0]   addr;
    logic [7:0]          len;
    logic [2:0]          size;
    logic [1:0]          burst;
  } mst_aw_t;

  // W beat, same on both sides
  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;     // Final beat of the burst
  } w_beat_t;

  typedef struct packed {
    logic [SLV_ID_W-1:0] id;
    logic [1:0]          resp;
  } slv_b_t;                     // Upstream B

  typedef struct packed {
    logic [MST_ID_W-1:0] id;
    logic [1:0]          resp;
  } mst_b_t;                     // Downstream B, prefixed ID

endpackage

/* design/rr_arbiter.sv */
// ----------------------------------------------------------
// Round-robin arbiter with lock-in for upstream AW requests
// Choice is held while the grant stalls
// ----------------------------------------------------------
`timescale 1ns/1ps

module rr_arbiter #(
  parameter int unsigned NumPorts = 4
) (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  input  logic                  [NumPorts-1:0] req_valid_i,  // AW valid per port
  input  axi_mux_pkg::slv_aw_t  [NumPorts-1:0] req_i,        // AW payload per port
  output logic                  [NumPorts-1:0] req_ready_o,  // AW ready per port
  output logic                                 gnt_valid_o,
  output axi_mux_pkg::slv_aw_t                 gnt_o,
  output axi_mux_pkg::port_idx_t               gnt_idx_o,    // Winning port
  input  logic                                 gnt_ready_i
);
  import axi_mux_pkg::*;

  port_idx_t prio_q, prio_d;          // First port to look at
  logic      lock_q, lock_d;          // Grant stalled, choice frozen
  port_idx_t lock_idx_q, lock_idx_d;  // Frozen choice
  port_idx_t pick_idx;                // Fresh search result
  logic      pick_valid;
  port_idx_t sel_idx;                 // Index actually presented

  // Search for the first valid port at or after the pointer
  always_comb begin : search
    int cand;
    cand       = 0;
    pick_valid = 1'b0;
    pick_idx   = prio_q;
    for (int i = 0; i < int'(NumPorts); i++) begin
      cand = (int'(prio_q) + i) % int'(NumPorts);  // Wrap around
      if (!pick_valid && req_valid_i[cand]) begin
        pick_valid = 1'b1;
        pick_idx   = port_idx_t'(cand);
      end
    end
  end

  assign sel_idx     = lock_q ? lock_idx_q : pick_idx;
  assign gnt_valid_o = lock_q ? req_valid_i[lock_idx_q] : pick_valid;
  assign gnt_o       = req_i[sel_idx];
  assign gnt_idx_o   = sel_idx;

  // Ready only to the presented port
  always_comb begin
    for (int p = 0; p < int'(NumPorts); p++) begin
      req_ready_o[p] = gnt_valid_o && gnt_ready_i && (sel_idx == port_idx_t'(p));
    end
  end

  // Lock and pointer update
  always_comb begin
    prio_d     = prio_q;
    lock_d     = lock_q;
    lock_idx_d = lock_idx_q;
    if (gnt_valid_o && gnt_ready_i) begin
      lock_d = 1'b0;                                     // Taken, release
      prio_d = (sel_idx == port_idx_t'(NumPorts - 1)) ? '0 : port_idx_t'(sel_idx + 1'b1);
    end else if (gnt_valid_o) begin
      lock_d     = 1'b1;                                 // Stalled, hold choice
      lock_idx_d = sel_idx;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      prio_q     <= '0;  // Port 0 favoured after reset
      lock_q     <= 1'b0;
      lock_idx_q <= '0;
    end else begin
      prio_q     <= prio_d;
      lock_q     <= lock_d;
      lock_idx_q <= lock_idx_d;
    end
  end

endmodule

/* design/aw_issue.sv */
// ----------------------------------------------------------
// AW issue stage
// Prepends the port index to the ID and records the issue
// order in the W order FIFO, once per AW
// ----------------------------------------------------------
`timescale 1ns/1ps

module aw_issue (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   gnt_valid_i,  // From arbiter
  input  axi_mux_pkg::slv_aw_t   gnt_i,
  input  axi_mux_pkg::port_idx_t gnt_idx_i,
  output logic                   gnt_ready_o,
  input  logic                   fifo_full_i,  // No room for another burst
  output logic                   fifo_push_o,
  output axi_mux_pkg::port_idx_t fifo_idx_o,
  output logic                   aw_valid_o,   // Toward spill register
  output axi_mux_pkg::mst_aw_t   aw_o,
  input  logic                   aw_ready_i
);
  import axi_mux_pkg::*;

  logic lock_q, lock_d;  // AW already pushed, waiting on downstream

  // Widen the ID, payload otherwise untouched
  assign aw_o.id    = {gnt_idx_i, gnt_i.id};
  assign aw_o.addr  = gnt_i.addr;
  assign aw_o.len   = gnt_i.len;
  assign aw_o.size  = gnt_i.size;
  assign aw_o.burst = gnt_i.burst;
  assign fifo_idx_o = gnt_idx_i;

  always_comb begin
    lock_d      = lock_q;
    gnt_ready_o = 1'b0;
    aw_valid_o  = 1'b0;
    fifo_push_o = 1'b0;
    if (lock_q) begin
      aw_valid_o = 1'b1;       // Keep valid, no second push
      if (aw_ready_i) begin
        gnt_ready_o = 1'b1;
        lock_d      = 1'b0;
      end
    end else if (gnt_valid_i && !fifo_full_i) begin
      aw_valid_o  = 1'b1;
      fifo_push_o = 1'b1;      // Record order on first presentation
      if (aw_ready_i) gnt_ready_o = 1'b1;
      else            lock_d      = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) lock_q <= 1'b0;
    else       lock_q <= lock_d;
  end

endmodule

/* design/id_fifo.sv */
// ----------------------------------------------------------
// Order FIFO of port indices
// One entry per issued AW, popped when its W burst ends
// ----------------------------------------------------------
`timescale 1ns/1ps

module id_fifo #(
  parameter int unsigned MaxWTrans = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   push_i,
  input  axi_mux_pkg::port_idx_t data_i,
  input  logic                   pop_i,
  output axi_mux_pkg::port_idx_t data_o,  // Head entry
  output logic                   full_o,
  output logic                   empty_o
);
  import axi_mux_pkg::*;

  localparam int unsigned PtrW = (MaxWTrans > 1) ? $clog2(MaxWTrans) : 1;
  localparam int unsigned CntW = $clog2(MaxWTrans + 1);

  port_idx_t         mem_q [MaxWTrans];  // Port index storage
  logic [PtrW-1:0]   wr_ptr_q, rd_ptr_q;
  logic [CntW-1:0]   cnt_q;              // Occupancy
  logic              do_push, do_pop;

  assign full_o  = (cnt_q == CntW'(MaxWTrans));
  assign empty_o = (cnt_q == '0);
  assign data_o  = mem_q[rd_ptr_q];

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  always_ff @(posedge clk_i) begin
    if (do_push) mem_q[wr_ptr_q] <= data_i;
  end

  // Pointers wrap at MaxWTrans for any depth
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      cnt_q    <= '0;
    end else begin
      if (do_push) wr_ptr_q <= (wr_ptr_q == PtrW'(MaxWTrans - 1)) ? '0 : wr_ptr_q + 1'b1;
      if (do_pop)  rd_ptr_q <= (rd_ptr_q == PtrW'(MaxWTrans - 1)) ? '0 : rd_ptr_q + 1'b1;
      case ({do_push, do_pop})
        2'b10:   cnt_q <= cnt_q + 1'b1;
        2'b01:   cnt_q <= cnt_q - 1'b1;
        default: cnt_q <= cnt_q;  // Both or neither
      endcase
    end
  end

endmodule

/* design/spill_register.sv */
// ----------------------------------------------------------
// Two-slot spill register for the downstream AW
// Full throughput, ready_o is registered only
// ----------------------------------------------------------
`timescale 1ns/1ps

module spill_register (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  logic                 valid_i,
  output logic                 ready_o,
  input  axi_mux_pkg::mst_aw_t data_i,
  output logic                 valid_o,
  input  logic                 ready_i,
  output axi_mux_pkg::mst_aw_t data_o
);
  import axi_mux_pkg::*;

  // ----------------------------------------------------------
  // Slot A takes new data, slot B holds the stalled item
  // ----------------------------------------------------------
  mst_aw_t a_data_q, b_data_q;
  logic    a_full_q, b_full_q;
  logic    a_fill, a_drain;
  logic    b_fill, b_drain;

  assign a_fill  = valid_i && ready_o;
  assign a_drain = a_full_q && !b_full_q;  // A leaves, downstream or into B
  assign b_fill  = a_drain && !ready_i;    // Downstream stalled, park A in B
  assign b_drain = b_full_q && ready_i;

  always_ff @(posedge clk_i) begin
    if (a_fill) a_data_q <= data_i;
    if (b_fill) b_data_q <= a_data_q;
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      a_full_q <= 1'b0;
      b_full_q <= 1'b0;
    end else begin
      if (a_fill || a_drain) a_full_q <= a_fill;
      if (b_fill || b_drain) b_full_q <= b_fill;
    end
  end

  assign ready_o = !a_full_q || !b_full_q;      // Room in at least one slot
  assign valid_o = a_full_q || b_full_q;
  assign data_o  = b_full_q ? b_data_q : a_data_q;  // B is always the older item

endmodule

/* design/w_steer.sv */
// ----------------------------------------------------------
// W steering from the order FIFO head
// Combinational, pops the head on the last beat
// ----------------------------------------------------------
`timescale 1ns/1ps

module w_steer #(
  parameter int unsigned NumPorts = 4
) (
  input  logic                                  [NumPorts-1:0] w_valid_i,
  input  axi_mux_pkg::w_beat_t                  [NumPorts-1:0] w_i,
  output logic                                  [NumPorts-1:0] w_ready_o,
  input  axi_mux_pkg::port_idx_t                               head_idx_i,
  input  logic                                                 fifo_empty_i,
  output logic                                                 mst_w_valid_o,
  output axi_mux_pkg::w_beat_t                                 mst_w_o,
  input  logic                                                 mst_w_ready_i,
  output logic                                                 pop_o
);
  import axi_mux_pkg::*;

  logic head_valid;  // Head port has a beat and an AW is pending

  assign mst_w_o = w_i[head_idx_i];  // Payload follows head, valid gates it

  always_comb begin
    head_valid = 1'b0;
    w_ready_o  = '0;
    for (int p = 0; p < int'(NumPorts); p++) begin
      if (!fifo_empty_i && (head_idx_i == port_idx_t'(p))) begin
        head_valid   = w_valid_i[p];
        w_ready_o[p] = mst_w_ready_i;  // Other ports stay blocked
      end
    end
  end

  assign mst_w_valid_o = head_valid;
  assign pop_o         = head_valid && mst_w_ready_i && mst_w_o.last;  // Burst done

endmodule

/* design/b_router.sv */
// ----------------------------------------------------------
// B response router
// Decodes the ID prefix and strips it toward upstream
// ----------------------------------------------------------
`timescale 1ns/1ps

module b_router #(
  parameter int unsigned NumPorts = 4
) (
  input  logic                                 mst_b_valid_i,
  input  axi_mux_pkg::mst_b_t                  mst_b_i,
  output logic                                 mst_b_ready_o,
  output logic                  [NumPorts-1:0] slv_b_valid_o,
  output axi_mux_pkg::slv_b_t   [NumPorts-1:0] slv_b_o,
  input  logic                  [NumPorts-1:0] slv_b_ready_i
);
  import axi_mux_pkg::*;

  port_idx_t route_idx;  // Destination port from ID top bits

  assign route_idx = mst_b_i.id[MST_ID_W-1 -: IDX_W];

  always_comb begin
    mst_b_ready_o = 1'b0;
    for (int p = 0; p < int'(NumPorts); p++) begin
      slv_b_o[p].id   = mst_b_i.id[SLV_ID_W-1:0];  // Prefix stripped
      slv_b_o[p].resp = mst_b_i.resp;
      slv_b_valid_o[p] = mst_b_valid_i && (route_idx == port_idx_t'(p));  // One-hot
      if (route_idx == port_idx_t'(p)) mst_b_ready_o = slv_b_ready_i[p];
    end
  end

endmodule

/* design/axi_mux_top.sv */
// ----------------------------------------------------------
// AXI4 write-path multiplexer, NumPorts upstream to one
// AW arbitrated and spilled, W steered by issue order,
// B routed back by ID prefix
// ----------------------------------------------------------
`timescale 1ns/1ps

module axi_mux_top #(
  parameter int unsigned NumPorts  = 4,  // 2 to 4
  parameter int unsigned MaxWTrans = 4   // Outstanding W bursts
) (
  input  logic                                 clk_i,
  input  logic                                 rst_i,
  // Upstream ports
  input  logic                  [NumPorts-1:0] slv_aw_valid_i,
  input  axi_mux_pkg::slv_aw_t  [NumPorts-1:0] slv_aw_i,
  output logic                  [NumPorts-1:0] slv_aw_ready_o,
  input  logic                  [NumPorts-1:0] slv_w_valid_i,
  input  axi_mux_pkg::w_beat_t  [NumPorts-1:0] slv_w_i,
  output logic                  [NumPorts-1:0] slv_w_ready_o,
  output logic                  [NumPorts-1:0] slv_b_valid_o,
  output axi_mux_pkg::slv_b_t   [NumPorts-1:0] slv_b_o,
  input  logic                  [NumPorts-1:0] slv_b_ready_i,
  // Downstream port
  output logic                                 mst_aw_valid_o,
  output axi_mux_pkg::mst_aw_t                 mst_aw_o,
  input  logic                                 mst_aw_ready_i,
  output logic                                 mst_w_valid_o,
  output axi_mux_pkg::w_beat_t                 mst_w_o,
  input  logic                                 mst_w_ready_i,
  input  logic                                 mst_b_valid_i,
  input  axi_mux_pkg::mst_b_t                  mst_b_i,
  output logic                                 mst_b_ready_o
);
  import axi_mux_pkg::*;

  slv_aw_t   gnt_aw;                   // Arbiter to issue stage
  port_idx_t gnt_idx;
  logic      gnt_valid, gnt_ready;
  mst_aw_t   issue_aw;                 // Issue stage to spill register
  logic      issue_valid, issue_ready;
  logic      fifo_push, fifo_pop;      // Order FIFO control
  logic      fifo_full, fifo_empty;
  port_idx_t fifo_push_idx, fifo_head_idx;

  // ----------------------------------------------------------
  // AW path
  // ----------------------------------------------------------
  rr_arbiter #(.NumPorts(NumPorts)) i_aw_arb (
    .clk_i(clk_i), .rst_i(rst_i),
    .req_valid_i(slv_aw_valid_i), .req_i(slv_aw_i), .req_ready_o(slv_aw_ready_o),
    .gnt_valid_o(gnt_valid), .gnt_o(gnt_aw), .gnt_idx_o(gnt_idx), .gnt_ready_i(gnt_ready)
  );

  aw_issue i_aw_issue (
    .clk_i(clk_i), .rst_i(rst_i),
    .gnt_valid_i(gnt_valid), .gnt_i(gnt_aw), .gnt_idx_i(gnt_idx), .gnt_ready_o(gnt_ready),
    .fifo_full_i(fifo_full), .fifo_push_o(fifo_push), .fifo_idx_o(fifo_push_idx),
    .aw_valid_o(issue_valid), .aw_o(issue_aw), .aw_ready_i(issue_ready)
  );

  spill_register i_aw_spill (
    .clk_i(clk_i), .rst_i(rst_i),
    .valid_i(issue_valid), .ready_o(issue_ready), .data_i(issue_aw),
    .valid_o(mst_aw_valid_o), .ready_i(mst_aw_ready_i), .data_o(mst_aw_o)
  );

  // ----------------------------------------------------------
  // W path
  // ----------------------------------------------------------
  id_fifo #(.MaxWTrans(MaxWTrans)) i_w_order (
    .clk_i(clk_i), .rst_i(rst_i),
    .push_i(fifo_push), .data_i(fifo_push_idx), .pop_i(fifo_pop),
    .data_o(fifo_head_idx), .full_o(fifo_full), .empty_o(fifo_empty)
  );

  w_steer #(.NumPorts(NumPorts)) i_w_steer (
    .w_valid_i(slv_w_valid_i), .w_i(slv_w_i), .w_ready_o(slv_w_ready_o),
    .head_idx_i(fifo_head_idx), .fifo_empty_i(fifo_empty),
    .mst_w_valid_o(mst_w_valid_o), .mst_w_o(mst_w_o), .mst_w_ready_i(mst_w_ready_i),
    .pop_o(fifo_pop)
  );

  // ----------------------------------------------------------
  // B path
  // ----------------------------------------------------------
  b_router #(.NumPorts(NumPorts)) i_b_router (
    .mst_b_valid_i(mst_b_valid_i), .mst_b_i(mst_b_i), .mst_b_ready_o(mst_b_ready_o),
    .slv_b_valid_o(slv_b_valid_o), .slv_b_o(slv_b_o), .slv_b_ready_i(slv_b_ready_i)
  );

endmodule

/* verification/tb_axi_mux.sv */
// ----------------------------------------------------------
// Testbench for the AXI4 write mux
// Four random upstream masters, a downstream slave model
// and checks on AW, W and B order and routing
// ----------------------------------------------------------
`timescale 1ns/1ps

module tb_axi_mux;
  import axi_mux_pkg::*;

  localparam int NP      = 4;     // Upstream ports
  localparam int MWT     = 4;     // Order FIFO depth
  localparam int NB      = 10;    // Bursts per port
  localparam int TIMEOUT = 5000;  // Cycles
  localparam int HOLD_LO = 30;    // W ready held low in this window
  localparam int HOLD_HI = 90;

  logic             clk, rst;
  logic [NP-1:0]    slv_aw_valid, slv_aw_ready, slv_w_valid, slv_w_ready;
  logic [NP-1:0]    slv_b_valid, slv_b_ready;
  slv_aw_t [NP-1:0] slv_aw;
  w_beat_t [NP-1:0] slv_w;
  slv_b_t  [NP-1:0] slv_b;
  logic             mst_aw_valid, mst_aw_ready, mst_w_valid, mst_w_ready;
  logic             mst_b_valid, mst_b_ready;
  mst_aw_t          mst_aw;
  w_beat_t          mst_w;
  mst_b_t           mst_b;

  integer              seed;
  slv_aw_t             aw_tab [NP][NB];                 // Bursts each port sends
  int                  aw_k   [NP] = '{default: 0};     // AWs granted per port
  int                  w_k    [NP] = '{default: 0};     // W bursts sent per port
  int                  w_beat [NP] = '{default: 0};
  int                  b_k    [NP] = '{default: 0};     // Bs received per port
  logic [NP-1:0]       owed   [NP] = '{default: '0};    // Must win before port wins again
  int                  grant_port [$];                  // Upstream grant order
  int                  grant_k    [$];
  logic [MST_ID_W-1:0] dn_aw_id   [$];                  // Slave side AW IDs
  int                  dn_aw_cnt  = 0;
  int                  dn_w_burst = 0;
  int                  dn_w_beat  = 0;
  int                  b_issued   = 0;
  int                  b_total    = 0;
  int                  max_out    = 0;                  // Peak AWs without W
  logic                b_acc      = 1'b0;               // Slave B taken last edge
  int                  cyc        = 0;
  int                  drain      = 0;
  int                  mism_cnt   = 0;
  int                  fail_cnt   = 0;

  axi_mux_top #(.NumPorts(NP), .MaxWTrans(MWT)) dut (
    .clk_i(clk), .rst_i(rst),
    .slv_aw_valid_i(slv_aw_valid), .slv_aw_i(slv_aw), .slv_aw_ready_o(slv_aw_ready),
    .slv_w_valid_i(slv_w_valid), .slv_w_i(slv_w), .slv_w_ready_o(slv_w_ready),
    .slv_b_valid_o(slv_b_valid), .slv_b_o(slv_b), .slv_b_ready_i(slv_b_ready),
    .mst_aw_valid_o(mst_aw_valid), .mst_aw_o(mst_aw), .mst_aw_ready_i(mst_aw_ready),
    .mst_w_valid_o(mst_w_valid), .mst_w_o(mst_w), .mst_w_ready_i(mst_w_ready),
    .mst_b_valid_i(mst_b_valid), .mst_b_i(mst_b), .mst_b_ready_o(mst_b_ready)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ----------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------
  // Downstream ID is the port index over the upstream ID
  function automatic logic [MST_ID_W-1:0] expected_aw_id(int port, logic [SLV_ID_W-1:0] id);
    return {port_idx_t'(port), id};
  endfunction

  // Destination port from the prefix and upstream ID from the low bits
  function automatic void split_b_id(input logic [MST_ID_W-1:0] id, output int port,
                                     output logic [SLV_ID_W-1:0] sid);
    port = int'(id[MST_ID_W-1:SLV_ID_W]);
    sid  = id[SLV_ID_W-1:0];
  endfunction

  function automatic logic [DATA_W-1:0] beat_data(int port, int burst, int beat);
    return {8'(port), 8'(burst), 8'(beat), 8'hc3};  // Unique per beat
  endfunction

  // Strobe pattern that shifts from beat to beat
  function automatic logic [STRB_W-1:0] beat_strb(int port, int burst, int beat);
    return STRB_W'(port + burst + beat + 1);
  endfunction

  task automatic compare_val(string name, logic [31:0] got, logic [31:0] exp);
    assert (got === exp) else begin
      mism_cnt++;
      $display("MISMATCH %s got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic expect_true(bit cond, string msg);
    assert (cond) else begin
      fail_cnt++;
      $display("%s", msg);
    end
  endtask

  task automatic build_bursts();
    logic [31:0] r;
    for (int p = 0; p < NP; p++) begin
      for (int k = 0; k < NB; k++) begin
        r = $random(seed);
        aw_tab[p][k].id    = r[3:0];
        aw_tab[p][k].len   = {6'd0, r[5:4]};        // One to four beats
        aw_tab[p][k].size  = r[6] ? 3'd2 : 3'd1;     // Four or two bytes per beat
        aw_tab[p][k].burst = r[7] ? 2'b01 : 2'b00;   // INCR or FIXED
        r = $random(seed);
        aw_tab[p][k].addr  = {r[31:2], 2'b00};
      end
    end
  endtask

  // ----------------------------------------------------------
  // Stimulus driven on each falling edge
  // ----------------------------------------------------------
  task automatic drive_inputs();
    logic [31:0] r;
    for (int p = 0; p < NP; p++) begin
      slv_aw_valid[p] = (aw_k[p] < NB);  // Held until granted
      if (aw_k[p] < NB) slv_aw[p] = aw_tab[p][aw_k[p]];
      slv_w_valid[p] = (w_k[p] < aw_k[p]);  // W only after its own AW
      if (w_k[p] < aw_k[p]) begin
        slv_w[p].data = beat_data(p, w_k[p], w_beat[p]);
        slv_w[p].strb = beat_strb(p, w_k[p], w_beat[p]);
        slv_w[p].last = (w_beat[p] == int'(aw_tab[p][w_k[p]].len));
      end
      r = $random(seed);
      slv_b_ready[p] = (r[1:0] != 2'b00);
    end
    r = $random(seed);
    mst_aw_ready = (r[1:0] != 2'b00);
    mst_w_ready  = (r[3:2] != 2'b00) && !(cyc >= HOLD_LO && cyc < HOLD_HI);
    if (b_acc) begin
      mst_b_valid = 1'b0;
      b_acc       = 1'b0;
    end
    // Slave answers a burst once both its AW and last W beat arrived
    if (!mst_b_valid && b_issued < dn_w_burst && b_issued < dn_aw_cnt) begin
      mst_b.id    = dn_aw_id[b_issued];
      mst_b.resp  = r[5:4];
      mst_b_valid = 1'b1;
      b_issued++;
    end
  endtask

  // ----------------------------------------------------------
  // Checker samples handshakes on the rising edge
  // ----------------------------------------------------------
  always @(posedge clk) begin : monitor
    int                  p;
    int                  k;
    int                  port;
    int                  out;
    logic [SLV_ID_W-1:0] sid;
    logic [NP-1:0]       exp_mask;
    if (!rst) begin
      for (int q = 0; q < NP; q++) begin
        if (slv_aw_valid[q] && slv_aw_ready[q]) begin  // Round-robin fairness
          expect_true(owed[q] == '0,
            $sformatf("Port %0d granted again while ports %b still waited", q, owed[q]));
          for (int o = 0; o < NP; o++) owed[o][q] = 1'b0;
          owed[q] = slv_aw_valid & ~(NP'(1) << q);
          grant_port.push_back(q);
          grant_k.push_back(aw_k[q]);
          aw_k[q]++;
        end
        if (slv_w_valid[q] && slv_w_ready[q]) begin
          if (slv_w[q].last) begin
            w_k[q]++;
            w_beat[q] = 0;
          end else w_beat[q]++;
        end
        if (slv_b_valid[q] && slv_b_ready[q]) begin
          expect_true(b_k[q] < NB, $sformatf("Extra B response on port %0d", q));
          if (b_k[q] < NB)
            compare_val($sformatf("slv_b[%0d].id", q), 32'(slv_b[q].id),
                        32'(aw_tab[q][b_k[q]].id));
          b_k[q]++;
          b_total++;
        end
      end
      // B routing
      split_b_id(mst_b.id, port, sid);
      exp_mask = mst_b_valid ? (NP'(1) << port) : '0;
      compare_val("slv_b_valid", 32'(slv_b_valid), 32'(exp_mask));
      if (mst_b_valid) begin
        compare_val("slv_b.id", 32'(slv_b[port].id), 32'(sid));
        compare_val("slv_b.resp", 32'(slv_b[port].resp), 32'(mst_b.resp));
        compare_val("mst_b_ready", 32'(mst_b_ready), 32'(slv_b_ready[port]));
        if (mst_b_ready) b_acc = 1'b1;
      end
      // Downstream AW follows upstream grant order
      if (mst_aw_valid && mst_aw_ready) begin
        expect_true(dn_aw_cnt < grant_port.size(), "Downstream AW without an upstream request");
        if (dn_aw_cnt < grant_port.size()) begin
          p = grant_port[dn_aw_cnt];
          k = grant_k[dn_aw_cnt];
          compare_val("mst_aw.id", 32'(mst_aw.id), 32'(expected_aw_id(p, aw_tab[p][k].id)));
          compare_val("mst_aw.addr", mst_aw.addr, aw_tab[p][k].addr);
          compare_val("mst_aw.len", 32'(mst_aw.len), 32'(aw_tab[p][k].len));
          compare_val("mst_aw.size", 32'(mst_aw.size), 32'(aw_tab[p][k].size));
          compare_val("mst_aw.burst", 32'(mst_aw.burst), 32'(aw_tab[p][k].burst));
        end
        dn_aw_id.push_back(mst_aw.id);
        dn_aw_cnt++;
      end
      // Downstream W bursts in the same order
      if (mst_w_valid && mst_w_ready) begin
        expect_true(dn_w_burst < grant_port.size(), "Downstream W beat without an issued AW");
        if (dn_w_burst < grant_port.size()) begin
          p = grant_port[dn_w_burst];
          k = grant_k[dn_w_burst];
          compare_val("mst_w.data", mst_w.data, beat_data(p, k, dn_w_beat));
          compare_val("mst_w.strb", 32'(mst_w.strb), 32'(beat_strb(p, k, dn_w_beat)));
          compare_val("mst_w.last", 32'(mst_w.last), 32'(dn_w_beat == int'(aw_tab[p][k].len)));
        end
        if (mst_w.last) begin
          dn_w_burst++;
          dn_w_beat = 0;
        end else dn_w_beat++;
      end
      out = dn_aw_cnt - dn_w_burst;  // AWs whose W burst is still open
      expect_true(out <= MWT, $sformatf("%0d AWs outstanding, limit is %0d", out, MWT));
      if (out > max_out) max_out = out;
    end
  end

  initial begin : main
    seed         = 32'hbc7a;
    rst          = 1'b1;
    slv_aw_valid = '0;
    slv_aw       = '0;
    slv_w_valid  = '0;
    slv_w        = '0;
    slv_b_ready  = '0;
    mst_aw_ready = 1'b0;
    mst_w_ready  = 1'b0;
    mst_b_valid  = 1'b0;
    mst_b        = '0;
    build_bursts();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    // Run until every B is back, then a few idle cycles
    while (cyc < TIMEOUT && drain < 10) begin
      drive_inputs();
      @(negedge clk);
      cyc++;
      if (b_total == NP * NB) drain++;
    end
    expect_true(cyc < TIMEOUT,
      $sformatf("Timeout, only %0d of %0d B responses came back", b_total, NP * NB));
    compare_val("dn_aw_cnt", 32'(dn_aw_cnt), 32'(NP * NB));
    compare_val("dn_w_burst", 32'(dn_w_burst), 32'(NP * NB));
    expect_true(max_out == MWT,
      $sformatf("Outstanding AWs peaked at %0d and never reached %0d", max_out, MWT));
    $display("Errors: %0d mismatches, %0d other failures", mism_cnt, fail_cnt);
    if (mism_cnt == 0 && fail_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* sim.f */
design/axi_mux_pkg.sv
design/rr_arbiter.sv
design/aw_issue.sv
design/id_fifo.sv
design/spill_register.sv
design/w_steer.sv
design/b_router.sv
design/axi_mux_top.sv
verification/tb_axi_mux.sv

/* Makefile */
SIM      ?= verilator
FLAGS    ?= --binary --timing --assert -j 0
TOP      ?= tb_axi_mux
FILELIST ?= sim.f
OBJ_DIR  ?= obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# Fails unless the pass message shows up in the output
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q "Testbench passed"

clean:
	rm -rf $(OBJ_DIR)
